// File: Makefile
# Verilator flow for the cache tag directory

TOP := tb_cache_dir
LOG := sim.log

.PHONY: all lint clean

# Build, run, and pass only if the log holds the pass message
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

obj_dir/V$(TOP): sources.f $(wildcard source/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --timing --top-module cache_dir_top -f sources.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_cache_dir.sv
/*
 * Self-checking testbench of the cache tag directory with 4 ways and tree PLRU.
 * The reference model only covers this configuration.
 * Expected responses ride a 3-entry pipeline that lines up with the 2-cycle latency.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_cache_dir
import cache_dir_pkg::*;
();

    localparam int WAYS      = 4;
    localparam int NUM_TESTS = 6;
    localparam int RAND_OPS  = 600;
    // Roughly 700 request cycles in all and four cycles allowed per request
    localparam int MAX_CYCLES = 4 * (RAND_OPS + 150);

    typedef struct packed {
        logic      valid;
        int        test_id;
        dir_resp_t resp;
    } exp_entry_t;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    dir_op_e               req_op;
    logic [DIR_ADDR_W-1:0] req_addr;
    logic                  resp_valid;
    dir_resp_t             resp;

    // Reference state of the directory
    dir_tag_t   m_tag   [DIR_SETS][WAYS];
    logic       m_valid [DIR_SETS][WAYS];
    logic [2:0] m_plru  [DIR_SETS];

    exp_entry_t  exp_a = '0;
    exp_entry_t  exp_b = '0;
    exp_entry_t  exp_c = '0;
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          cur_test;
    int          chk_cnt [NUM_TESTS];
    int          err_cnt [NUM_TESTS];
    int          total_chk;
    int          total_err;
    string       test_names [NUM_TESTS] = '{"reset_miss", "fill_order", "plru_evict",
                                            "invalidate", "back_to_back", "random_mix"};

    cache_dir_top #(
        .WAYS         (WAYS),
        .POLICY       (VICTIM_PLRU)
    ) UUT (
        .clk_i        (clk),
        .reset_i      (reset),
        .req_valid_i  (req_valid),
        .req_op_i     (req_op),
        .req_addr_i   (req_addr),
        .resp_valid_o (resp_valid),
        .resp_o       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Hard stop in case the run never reaches its end
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // Entry a is loaded with the request and entry c is due at the response edge
    always @(posedge clk) begin
        exp_b <= exp_a;
        exp_c <= exp_b;
    end

    resp_check: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> (resp == exp_c.resp))
    else begin
        $display("error: test %s expected %h actual %h", test_names[$sampled(exp_c.test_id)],
                 $sampled(exp_c.resp), $sampled(resp));
        err_cnt[$sampled(exp_c.test_id)] = err_cnt[$sampled(exp_c.test_id)] + 1;
    end

    // Also catches a response that shows up with no request behind it
    latency_check: assert property (@(posedge clk) disable iff (reset)
        resp_valid == $past(req_valid, 2))
    else begin
        $display("test %s: response strobe did not follow the request strobe by two cycles",
                 test_names[cur_test]);
        err_cnt[cur_test] = err_cnt[cur_test] + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] make_addr(dir_tag_t tag, dir_set_t set, logic [3:0] off);
        return {tag, set, off};
    endfunction

    // Root bit 0 picks the pair of ways 0 and 1 and bits 1 and 2 pick inside each pair
    function automatic logic [1:0] plru_pick(logic [2:0] bits);
        if (bits[0]) begin
            return {1'b1, bits[2]};
        end else begin
            return {1'b0, bits[1]};
        end
    endfunction

    function automatic logic [2:0] plru_touch(logic [2:0] bits, logic [1:0] way);
        logic [2:0] nb;
        nb    = bits;
        nb[0] = ~way[1];
        if (way[1]) begin
            nb[2] = ~way[0];
        end else begin
            nb[1] = ~way[0];
        end
        return nb;
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < DIR_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
    endfunction

    // Applies one request to the reference state and returns its response
    function automatic dir_resp_t model_step(dir_op_e op, logic [31:0] addr);
        dir_set_t   s;
        dir_tag_t   t;
        dir_resp_t  r;
        logic       hit;
        logic       have_inv;
        logic [1:0] hw;
        logic [1:0] vw;
        s        = addr[7:4];
        t        = addr[31:8];
        r        = '0;
        hit      = 1'b0;
        have_inv = 1'b0;
        hw       = '0;
        vw       = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && (m_tag[s][w] == t)) begin
                hit = 1'b1;
                hw  = 2'(w);
            end
            if (!have_inv && !m_valid[s][w]) begin
                have_inv = 1'b1;
                vw       = 2'(w);
            end
        end
        if (hit) begin
            r.hit = 1'b1;
            r.way = {1'b0, hw};
        end
        case (op)
            DIR_LOOKUP: begin
                if (hit) begin
                    m_plru[s] = plru_touch(m_plru[s], hw);
                end
            end
            DIR_ALLOC: begin
                if (hit) begin
                    m_plru[s] = plru_touch(m_plru[s], hw);
                end else begin
                    if (!have_inv) begin
                        vw = plru_pick(m_plru[s]);
                    end
                    r.way   = {1'b0, vw};
                    r.evict = m_valid[s][vw];
                    if (m_valid[s][vw]) begin
                        r.evict_tag = m_tag[s][vw];
                    end
                    m_tag[s][vw]   = t;
                    m_valid[s][vw] = 1'b1;
                    m_plru[s]      = plru_touch(m_plru[s], vw);
                end
            end
            // Invalidation leaves the tree alone
            DIR_INVAL: begin
                if (hit) begin
                    m_valid[s][hw] = 1'b0;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic drive_req(dir_op_e op, logic [31:0] addr);
        exp_entry_t e;
        e.valid   = 1'b1;
        e.test_id = cur_test;
        e.resp    = model_step(op, addr);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        exp_a     <= e;
        chk_cnt[cur_test] = chk_cnt[cur_test] + 1;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        req_valid <= 1'b0;
        exp_a     <= '0;
    endtask

    // Reset is raised in the current edge step and sampled high at the next 8 edges
    task automatic apply_reset();
        model_clear();
        reset <= 1'b1;
        repeat (8) begin
            drive_idle();
        end
        reset <= 1'b0;
    endtask

    // Runs idle cycles until every queued response has been compared
    task automatic drain_pipe();
        do begin
            drive_idle();
        end while (exp_a.valid || exp_b.valid || exp_c.valid || resp_valid);
    endtask

    task automatic finish_test();
        drain_pipe();
        total_chk = total_chk + chk_cnt[cur_test];
        total_err = total_err + err_cnt[cur_test];
        $display("test %-12s responses %0d errors %0d %s", test_names[cur_test],
                 chk_cnt[cur_test], err_cnt[cur_test],
                 (err_cnt[cur_test] == 0) ? "ok" : "MISMATCH");
        cur_test = cur_test + 1;
    endtask

    initial begin
        logic [31:0] rnd;
        int          set_k;
        int          tag_k;
        dir_set_t    rand_sets [3];
        dir_op_e     op;
        req_valid = 1'b0;
        req_op    = DIR_LOOKUP;
        req_addr  = '0;
        reset     = 1'b1;
        lcg_state = 32'd55587;
        rand_sets = '{4'd1, 4'd6, 4'd11};
        cur_test  = 0;
        total_chk = 0;
        total_err = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            chk_cnt[i] = 0;
            err_cnt[i] = 0;
        end
        apply_reset();

        // Empty directory with idle cycles first so a stray response would show
        repeat (6) drive_idle();
        for (int i = 0; i < 12; i++) begin
            rnd = lcg_next();
            drive_req((i % 4 == 3) ? DIR_INVAL : DIR_LOOKUP, rnd);
        end
        finish_test();

        // Set 2 fills in way order and then every tag hits where it went
        for (int i = 0; i < WAYS; i++) begin
            drive_req(DIR_ALLOC, make_addr(dir_tag_t'(24'h200 + i), 4'd2, 4'(i * 3)));
        end
        for (int i = WAYS - 1; i >= 0; i--) begin
            drive_req(DIR_LOOKUP, make_addr(dir_tag_t'(24'h200 + i), 4'd2, 4'(i)));
        end
        finish_test();

        // Hits reorder the tree before each eviction in the full set
        drive_req(DIR_LOOKUP, make_addr(24'h202, 4'd2, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h200, 4'd2, 4'h0));
        drive_req(DIR_ALLOC,  make_addr(24'h2a0, 4'd2, 4'h5));
        drive_req(DIR_LOOKUP, make_addr(24'h201, 4'd2, 4'h0));
        drive_req(DIR_ALLOC,  make_addr(24'h2a1, 4'd2, 4'h0));
        drive_req(DIR_ALLOC,  make_addr(24'h2a2, 4'd2, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h2a0, 4'd2, 4'h0));
        drive_req(DIR_ALLOC,  make_addr(24'h2a3, 4'd2, 4'hf));
        finish_test();

        // Way 1 of set 5 is freed and the next fill must reuse it
        for (int i = 0; i < WAYS; i++) begin
            drive_req(DIR_ALLOC, make_addr(dir_tag_t'(24'h500 + i), 4'd5, 4'h0));
        end
        drive_req(DIR_INVAL,  make_addr(24'h501, 4'd5, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h501, 4'd5, 4'h0));
        drive_req(DIR_ALLOC,  make_addr(24'h5f0, 4'd5, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h5f0, 4'd5, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h500, 4'd5, 4'h0));
        finish_test();

        // Every request follows the previous one in the same set directly
        drive_req(DIR_ALLOC,  make_addr(24'h900, 4'd9, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h900, 4'd9, 4'h0));
        drive_req(DIR_ALLOC,  make_addr(24'h901, 4'd9, 4'h0));
        drive_req(DIR_ALLOC,  make_addr(24'h901, 4'd9, 4'h0));
        drive_req(DIR_INVAL,  make_addr(24'h900, 4'd9, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h900, 4'd9, 4'h0));
        for (int i = 2; i < 7; i++) begin
            drive_req(DIR_ALLOC, make_addr(dir_tag_t'(24'h900 + i), 4'd9, 4'h0));
        end
        drive_req(DIR_LOOKUP, make_addr(24'h905, 4'd9, 4'h0));
        drive_req(DIR_LOOKUP, make_addr(24'h906, 4'd9, 4'h0));
        finish_test();

        // Three sets and six tags keep the sets full and evicting
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd   = lcg_next();
            set_k = int'(rnd[23:16]) % 3;
            tag_k = int'(rnd[31:24]) % 6;
            if (rnd[14:12] < 3'd3) begin
                op = DIR_LOOKUP;
            end else if (rnd[14:12] < 3'd7) begin
                op = DIR_ALLOC;
            end else begin
                op = DIR_INVAL;
            end
            if (rnd[7:5] == 3'd0) begin
                drive_idle();
            end
            drive_req(op, make_addr(dir_tag_t'(24'hc00 + tag_k), rand_sets[set_k], rnd[11:8]));
        end
        drain_pipe();
        apply_reset();
        for (int s = 0; s < 3; s++) begin
            for (int t = 0; t < 6; t++) begin
                drive_req(DIR_LOOKUP, make_addr(dir_tag_t'(24'hc00 + t), rand_sets[s], 4'h0));
            end
        end
        finish_test();

        $display("summary: tests %0d responses %0d errors %0d", cur_test, total_chk, total_err);
        if (total_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cache_dir_pkg.sv
/*
 * Shared types of the cache tag directory.
 * Address split is fixed: 4 offset bits, 4 set bits, 24 tag bits.
 * Way count is limited to DIR_MAX_WAYS and must be a power of two.
 */
`default_nettype none

package cache_dir_pkg;

    // Address geometry
    localparam int DIR_ADDR_W   = 32;
    localparam int DIR_OFFSET_W = 4;
    localparam int DIR_SETS     = 16;
    localparam int DIR_MAX_WAYS = 8;

    // Derived field widths
    localparam int DIR_SET_W = $clog2(DIR_SETS);
    localparam int DIR_TAG_W = DIR_ADDR_W - DIR_SET_W - DIR_OFFSET_W;
    localparam int DIR_WAY_W = $clog2(DIR_MAX_WAYS);

    typedef logic [DIR_SET_W-1:0] dir_set_t;
    typedef logic [DIR_TAG_W-1:0] dir_tag_t;
    typedef logic [DIR_WAY_W-1:0] dir_way_idx_t;

    // Request operations
    typedef enum logic [1:0] {
        DIR_LOOKUP = 2'd0,
        DIR_ALLOC  = 2'd1,
        DIR_INVAL  = 2'd2
    } dir_op_e;

    // Replacement policy when all ways of a set are valid
    typedef enum logic [0:0] {
        VICTIM_PLRU   = 1'b0,
        VICTIM_RANDOM = 1'b1
    } dir_victim_e;

    // Request after the address split, 30 bits
    typedef struct packed {
        dir_op_e  op;
        dir_set_t set;
        dir_tag_t tag;
    } dir_req_t;

    // Directory write broadcast to all banks, 29 bits
    typedef struct packed {
        dir_set_t set;
        dir_tag_t tag;
        logic     valid;
    } dir_wr_t;

    // Response seen at the top level, 29 bits
    typedef struct packed {
        logic         hit;
        dir_way_idx_t way;
        logic         evict;
        dir_tag_t     evict_tag;
    } dir_resp_t;

endpackage

`default_nettype wire

// File: source/cache_dir_top.sv
/*
 * Tag directory of a set-associative cache, fixed latency of 2 cycles.
 * No back-pressure, a request may enter every cycle.
 * WAYS must be a power of two from 2 to 8.
 */
`timescale 1ns/1ns
`default_nettype none

module cache_dir_top
import cache_dir_pkg::*;
#(
    parameter int          WAYS   = 4,
    parameter dir_victim_e POLICY = VICTIM_PLRU
)
(
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  logic                  req_valid_i,
    input  dir_op_e               req_op_i,
    input  logic [DIR_ADDR_W-1:0] req_addr_i,

    output logic                  resp_valid_o,
    output dir_resp_t             resp_o
);

    logic            s1_valid;
    dir_req_t        s1_req;
    logic [WAYS-1:0] hit_vec;
    logic [WAYS-1:0] valid_vec;
    dir_tag_t        tag_vec [WAYS];
    logic [WAYS-1:0] wr_en;
    dir_wr_t         wr;

    dir_req_stage req_stage_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .s1_valid_o  (s1_valid),
        .s1_req_o    (s1_req)
    );

    // One bank per way, all reading the same stage-1 set
    for (genvar g = 0; g < WAYS; g++) begin : way_bank_gen
        dir_way_bank way_bank_i (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .s1_req_i (s1_req),
            .wr_en_i  (wr_en[g]),
            .wr_i     (wr),
            .hit_o    (hit_vec[g]),
            .valid_o  (valid_vec[g]),
            .tag_o    (tag_vec[g])
        );
    end

    dir_resp_stage #(
        .WAYS         (WAYS),
        .POLICY       (POLICY)
    ) resp_stage_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .s1_valid_i   (s1_valid),
        .s1_req_i     (s1_req),
        .hit_vec_i    (hit_vec),
        .valid_vec_i  (valid_vec),
        .tag_vec_i    (tag_vec),
        .wr_en_o      (wr_en),
        .wr_o         (wr),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

endmodule

`default_nettype wire

// File: source/dir_req_stage.sv
/*
 * Request register of the tag directory.
 * Accepts one request per cycle, there is no stall path.
 * The line offset bits of the address are dropped here.
 */
`timescale 1ns/1ns
`default_nettype none

module dir_req_stage
import cache_dir_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,

    // Incoming request strobe and payload
    input  logic      req_valid_i,
    input  dir_op_e   req_op_i,
    input  logic [DIR_ADDR_W-1:0] req_addr_i,

    // Stage-1 request towards the banks and the response stage
    output logic      s1_valid_o,
    output dir_req_t  s1_req_o
);

    dir_req_t req_split;
    logic     s1_valid_q;
    dir_req_t s1_req_q;

    // Set index sits right above the offset, the tag takes the upper bits
    always_comb begin
        req_split.op  = req_op_i;
        req_split.set = req_addr_i[DIR_OFFSET_W +: DIR_SET_W];
        req_split.tag = req_addr_i[DIR_ADDR_W-1 -: DIR_TAG_W];
    end

    // The strobe is control state and is cleared on reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_valid_i;
        end
    end

    // Payload is only captured with a valid strobe
    // Banks still read the held set when idle, which is harmless
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            s1_req_q <= req_split;
        end
    end

    assign s1_valid_o = s1_valid_q;
    assign s1_req_o   = s1_req_q;

endmodule

`default_nettype wire

// File: source/dir_resp_stage.sv
/*
 * Second pipeline stage of the tag directory.
 * Decides hit, victim and directory write, and presents the response.
 * Writes and policy updates take effect at the end of the response cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module dir_resp_stage
import cache_dir_pkg::*;
#(
    parameter int          WAYS   = 4,
    parameter dir_victim_e POLICY = VICTIM_PLRU
)
(
    input  logic            clk_i,
    input  logic            reset_i,

    input  logic            s1_valid_i,
    input  dir_req_t        s1_req_i,

    // Registered bank results for the stage-2 request
    input  logic [WAYS-1:0] hit_vec_i,
    input  logic [WAYS-1:0] valid_vec_i,
    input  dir_tag_t        tag_vec_i [WAYS],

    output logic [WAYS-1:0] wr_en_o,
    output dir_wr_t         wr_o,

    output logic            resp_valid_o,
    output dir_resp_t       resp_o
);

    logic         s2_valid_q;
    dir_req_t     s2_req_q;
    logic         hit_any;
    dir_way_idx_t hit_way;
    dir_way_idx_t victim;
    logic         victim_valid;
    dir_tag_t     victim_tag;
    logic         updt;
    dir_way_idx_t updt_way;
    dir_way_idx_t wr_way;
    logic         wr_any;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s2_valid_q <= 1'b0;
        end else begin
            s2_valid_q <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s2_req_q <= s1_req_i;
    end

    // At most one way hits, so a plain OR of indices would do as well
    always_comb begin
        hit_any      = |hit_vec_i;
        hit_way      = '0;
        victim_valid = 1'b0;
        victim_tag   = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (hit_vec_i[i]) begin
                hit_way = dir_way_idx_t'(i);
            end
            if (victim == dir_way_idx_t'(i)) begin
                victim_valid = valid_vec_i[i];
                victim_tag   = tag_vec_i[i];
            end
        end
    end

    dir_victim_sel #(
        .WAYS        (WAYS),
        .POLICY      (POLICY)
    ) victim_sel_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .set_i       (s2_req_q.set),
        .valid_vec_i (valid_vec_i),
        .updt_i      (updt),
        .updt_way_i  (updt_way),
        .victim_o    (victim)
    );

    // Operation decode for the request in the response cycle
    always_comb begin
        updt      = 1'b0;
        updt_way  = hit_way;
        wr_any    = 1'b0;
        wr_way    = hit_way;
        wr_o.set  = s2_req_q.set;
        wr_o.tag  = s2_req_q.tag;
        wr_o.valid = 1'b1;
        resp_o.hit       = s2_valid_q && hit_any;
        resp_o.way       = hit_any ? hit_way : '0;
        resp_o.evict     = 1'b0;
        resp_o.evict_tag = '0;
        if (s2_valid_q) begin
            case (s2_req_q.op)
                DIR_LOOKUP: updt = hit_any;
                DIR_ALLOC: begin
                    updt = 1'b1;
                    if (!hit_any) begin
                        // Miss fills the victim, an occupied victim is evicted
                        updt_way         = victim;
                        wr_any           = 1'b1;
                        wr_way           = victim;
                        resp_o.way       = victim;
                        resp_o.evict     = victim_valid;
                        resp_o.evict_tag = victim_valid ? victim_tag : '0;
                    end
                end
                DIR_INVAL: begin
                    // Invalidation leaves the replacement state alone
                    wr_any     = hit_any;
                    wr_o.valid = 1'b0;
                end
                default: updt = 1'b0;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            wr_en_o[i] = wr_any && (wr_way == dir_way_idx_t'(i));
        end
    end

    assign resp_valid_o = s2_valid_q;

endmodule

`default_nettype wire

// File: source/dir_victim_sel.sv
/*
 * Victim way selection for one set at a time.
 * An invalid way always wins, lowest number first.
 * With a full set, POLICY picks tree PLRU or an 8-bit LFSR.
 * WAYS must be a power of two from 2 to 8.
 */
`timescale 1ns/1ns
`default_nettype none

module dir_victim_sel
import cache_dir_pkg::*;
#(
    parameter int          WAYS   = 4,
    parameter dir_victim_e POLICY = VICTIM_PLRU
)
(
    input  logic            clk_i,
    input  logic            reset_i,

    // Set under replacement and its valid bits
    input  dir_set_t        set_i,
    input  logic [WAYS-1:0] valid_vec_i,

    // Access notification, applied at the clock edge
    input  logic            updt_i,
    input  dir_way_idx_t    updt_way_i,

    output dir_way_idx_t    victim_o
);

    localparam int LW = $clog2(WAYS);

    logic         any_inv;
    dir_way_idx_t inv_way;
    dir_way_idx_t policy_way;

    // Priority search, scanning downwards leaves the lowest invalid way
    always_comb begin
        any_inv = 1'b0;
        inv_way = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (!valid_vec_i[i]) begin
                any_inv = 1'b1;
                inv_way = dir_way_idx_t'(i);
            end
        end
    end

    if (POLICY == VICTIM_PLRU) begin : plru_gen
        // One tree per set, node 0 is the root and node n has children 2n+1, 2n+2
        logic [WAYS-2:0] plru_q [DIR_SETS];
        logic [WAYS-2:0] plru_cur;
        logic [WAYS-2:0] plru_nxt;

        assign plru_cur = plru_q[set_i];

        // Walk from the root, a zero bit points to the lower half
        always_comb begin
            int node;
            node       = 0;
            policy_way = '0;
            for (int lvl = 0; lvl < LW; lvl++) begin
                policy_way[LW-1-lvl] = plru_cur[node];
                node = 2 * node + 1 + int'(plru_cur[node]);
            end
        end

        // Every node on the path of the accessed way turns away from it
        always_comb begin
            int   node;
            logic dir;
            node     = 0;
            plru_nxt = plru_cur;
            for (int lvl = 0; lvl < LW; lvl++) begin
                dir            = updt_way_i[LW-1-lvl];
                plru_nxt[node] = ~dir;
                node           = 2 * node + 1 + int'(dir);
            end
        end

        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                for (int s = 0; s < DIR_SETS; s++) begin
                    plru_q[s] <= '0;
                end
            end else if (updt_i) begin
                plru_q[set_i] <= plru_nxt;
            end
        end
    end else begin : random_gen
        // Fibonacci LFSR with taps 8, 6, 5 and 4, shifting left
        logic [7:0] lfsr_q;
        logic       lfsr_fb;

        assign lfsr_fb    = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
        assign policy_way = dir_way_idx_t'(lfsr_q[LW-1:0]);

        // A choice among valid ways is only made for a full set
        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                lfsr_q <= 8'h01;
            end else if (updt_i && !any_inv) begin
                lfsr_q <= {lfsr_q[6:0], lfsr_fb};
            end
        end
    end

    assign victim_o = any_inv ? inv_way : policy_way;

endmodule

`default_nettype wire

// File: source/dir_way_bank.sv
/*
 * Tag and valid storage of one directory way.
 * Read data is registered, so results arrive one cycle after the set.
 * A write to the set being read is forwarded into the read result.
 */
`timescale 1ns/1ns
`default_nettype none

module dir_way_bank
import cache_dir_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,

    // Stage-1 request, only set and tag are used
    input  dir_req_t s1_req_i,

    // Write port shared by all banks, enabled per way
    input  logic     wr_en_i,
    input  dir_wr_t  wr_i,

    // Registered read results for the stage-1 set
    output logic     hit_o,
    output logic     valid_o,
    output dir_tag_t tag_o
);

    dir_tag_t             tag_q [DIR_SETS];
    logic [DIR_SETS-1:0]  valid_q;

    logic     rd_valid;
    dir_tag_t rd_tag;
    logic     rd_hit;

    logic     hit_q;
    logic     valid_out_q;
    dir_tag_t tag_out_q;

    // Array read with bypass of the write that lands at the same edge
    always_comb begin
        rd_valid = valid_q[s1_req_i.set];
        rd_tag   = tag_q[s1_req_i.set];
        if (wr_en_i && (wr_i.set == s1_req_i.set)) begin
            rd_valid = wr_i.valid;
            rd_tag   = wr_i.tag;
        end
        rd_hit = rd_valid && (rd_tag == s1_req_i.tag);
    end

    // Valid bits start cleared so every set looks empty after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_i.set] <= wr_i.valid;
        end
    end

    // Tags carry no reset, they are qualified by the valid bits
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[wr_i.set] <= wr_i.tag;
        end
    end

    // Output registers feeding stage 2
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hit_q       <= 1'b0;
            valid_out_q <= 1'b0;
        end else begin
            hit_q       <= rd_hit;
            valid_out_q <= rd_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        tag_out_q <= rd_tag;
    end

    assign hit_o   = hit_q;
    assign valid_o = valid_out_q;
    assign tag_o   = tag_out_q;

endmodule

`default_nettype wire

// File: sources.f
source/cache_dir_pkg.sv
source/dir_req_stage.sv
source/dir_way_bank.sv
source/dir_victim_sel.sv
source/dir_resp_stage.sv
source/cache_dir_top.sv
sim/tb_cache_dir.sv
